/* sources.f */
hw/exPkg.sv
hw/exOperandLatch.sv
hw/exAlu.sv
hw/exMulAcc.sv
hw/exBranch.sv
hw/exResultStage.sv
hw/exStage.sv
verif/exChecker.sv
verif/tbExStage.sv

/* Bender.yml */
package:
  name: ex_stage

sources:
  - hw/exPkg.sv
  - hw/exOperandLatch.sv
  - hw/exAlu.sv
  - hw/exMulAcc.sv
  - hw/exBranch.sv
  - hw/exResultStage.sv
  - hw/exStage.sv
  - target: simulation
    files:
      - verif/exChecker.sv
      - verif/tbExStage.sv

/* verif/tbExStage.sv */
/*
 * Execute stage testbench: clock, reset, directed stimulus table,
 * random ALU entries, DUT and checker instances
 */
`timescale 1ns/1ps

module tbExStage;
    import exPkg::*;

    logic           Clock;
    logic           arstN;
    exDecode_s      dec;
    exMem_s         exMem;
    exFlags_s       flags;
    logic [31:0]    pcOut;
    logic           taken;

    // Record handed to the checker alongside each decode bundle
    logic           recValid;
    logic           recModel;             // Checker derives expected values
    logic [127:0]   recName;
    exMem_s         recMem;
    exFlags_s       recFlags;
    logic [31:0]    recPc;
    logic           recTaken;
    int             errorCount;
    int             checkCount;
    logic           busy;
    int             timeouts;
    int             seed;

    // Stimulus table
    logic [127:0]   names[$];
    exDecode_s      decs[$];
    exMem_s         expMems[$];
    exFlags_s       expFlags[$];
    logic [31:0]    expPcs[$];
    logic           expTakens[$];
    logic           fromModel[$];

    exStage i_exStage (
        .Clock (Clock),
        .arstN (arstN),
        .dec   (dec),
        .exMem (exMem),
        .flags (flags),
        .pcOut (pcOut),
        .taken (taken)
    );

    exChecker i_exChecker (
        .Clock      (Clock),
        .arstN      (arstN),
        .dec        (dec),
        .exMem      (exMem),
        .flags      (flags),
        .pcOut      (pcOut),
        .taken      (taken),
        .recValid   (recValid),
        .recModel   (recModel),
        .recName    (recName),
        .recMem     (recMem),
        .recFlags   (recFlags),
        .recPc      (recPc),
        .recTaken   (recTaken),
        .errorCount (errorCount),
        .checkCount (checkCount),
        .busy       (busy)
    );

    initial begin
        Clock = 1'b0;
        forever #50 Clock = ~Clock;       // 100 ns period
    end

    function automatic exDecode_s mkDec(input opClass_e op, input logic [5:0] func,
                                        input logic aluSrc, input logic regWrite,
                                        input logic memRead, input logic memWrite,
                                        input logic [4:0] rAddr, input logic [4:0] shamt,
                                        input logic [31:0] a, input logic [31:0] b,
                                        input logic [31:0] imm, input logic [31:0] pc);
        exDecode_s d;
        d.opClass   = op;
        d.func      = func;
        d.aluSrc    = aluSrc;
        d.regWrite  = regWrite;
        d.memRead   = memRead;
        d.memtoReg  = memRead;            // Loads write back memory data
        d.memWrite  = memWrite;
        d.rAddr     = rAddr;
        d.shamt     = shamt;
        d.a         = a;
        d.b         = b;
        d.immediate = imm;
        d.pc        = pc;
        return d;
    endfunction

    // Controls and store data pass through, result and write gating come from the entry
    task automatic addEntry(input logic [127:0] name, input exDecode_s d,
                            input logic [31:0] result, input logic regWrite,
                            input logic [3:0] f, input logic [31:0] pc, input logic tk);
        exMem_s m;
        m = '{result: result, rtData: d.b, rAddr: d.rAddr, regWrite: regWrite,
              memRead: d.memRead, memtoReg: d.memtoReg, memWrite: d.memWrite};
        names.push_back(name);
        decs.push_back(d);
        expMems.push_back(m);
        expFlags.push_back(f);
        expPcs.push_back(pc);
        expTakens.push_back(tk);
        fromModel.push_back(1'b0);
    endtask

    task automatic buildTable();
        exDecode_s d;
        logic [5:0] fsel[4];
        fsel = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_XOR};
        // Flags column is {c, z, o, n}
        addEntry("add_ovf", mkDec(OP_ALU, ALU_ADD, 0, 1, 0, 0, 2, 0, 32'h7fffffff, 1, 0, 'h100),
                 32'h80000000, 1, 4'b0011, 'h104, 0);
        addEntry("addu_carry", mkDec(OP_ALU, ALU_ADDU, 1, 1, 0, 0, 3, 0, 32'hffffffff, 'h55, 1,
                 'h104), 0, 1, 4'b1100, 'h108, 0);
        addEntry("sub_borrow", mkDec(OP_ALU, ALU_SUB, 0, 1, 0, 0, 4, 0, 1, 2, 0, 'h108),
                 32'hffffffff, 1, 4'b0001, 'h10c, 0);
        addEntry("sub_noborrow", mkDec(OP_ALU, ALU_SUB, 0, 1, 0, 0, 4, 0, 5, 3, 0, 'h10c),
                 2, 1, 4'b1000, 'h110, 0);
        addEntry("slt", mkDec(OP_ALU, ALU_SLT, 0, 1, 0, 0, 5, 0, 32'hffffffff, 1, 0, 'h110),
                 1, 1, 4'b0000, 'h114, 0);
        addEntry("sltu", mkDec(OP_ALU, ALU_SLTU, 0, 1, 0, 0, 5, 0, 32'hffffffff, 1, 0, 'h114),
                 0, 1, 4'b0100, 'h118, 0);
        addEntry("sra_neg", mkDec(OP_ALU, ALU_SRA, 0, 1, 0, 0, 6, 4, 0, 32'h80000000, 0, 'h118),
                 32'hf8000000, 1, 4'b0001, 'h11c, 0);
        addEntry("or_imm_store", mkDec(OP_ALU, ALU_OR, 1, 0, 0, 1, 0, 0, 'hf0, 'hdead, 'h0f,
                 'h11c), 'hff, 0, 4'b0000, 'h120, 0);
        addEntry("load_addr", mkDec(OP_ALU, ALU_ADD, 1, 1, 1, 0, 9, 0, 'h1000, 'h7, 'h10, 'h120),
                 'h1010, 1, 4'b0000, 'h124, 0);
        // Accumulator starts at zero
        addEntry("mult", mkDec(OP_MULACC, MUL_MULT, 0, 1, 0, 0, 4, 0, 32'hfffffffd, 7, 0, 'h124),
                 32'hffffffeb, 1, 4'b0100, 'h128, 0);
        addEntry("madd1", mkDec(OP_MULACC, MUL_MADD, 0, 0, 0, 0, 0, 0, 'h10000, 'h10000, 0,
                 'h128), 0, 0, 4'b0100, 'h12c, 0);
        addEntry("madd2", mkDec(OP_MULACC, MUL_MADD, 0, 0, 0, 0, 0, 0, 32'hffffffff, 1, 0, 'h12c),
                 0, 0, 4'b0000, 'h130, 0);
        addEntry("mflo", mkDec(OP_MULACC, MUL_MFLO, 0, 1, 0, 0, 5, 0, 0, 0, 0, 'h130),
                 32'hffffffff, 1, 4'b1000, 'h134, 0);
        addEntry("mfhi", mkDec(OP_MULACC, MUL_MFHI, 0, 1, 0, 0, 6, 0, 0, 0, 0, 'h134),
                 0, 1, 4'b1000, 'h138, 0);
        addEntry("clracc", mkDec(OP_MULACC, MUL_CLRACC, 0, 0, 0, 0, 0, 0, 0, 0, 0, 'h138),
                 0, 0, 4'b1000, 'h13c, 0);
        addEntry("mflo_cleared", mkDec(OP_MULACC, MUL_MFLO, 0, 1, 0, 0, 5, 0, 0, 0, 0, 'h13c),
                 0, 1, 4'b0100, 'h140, 0);
        // Flags hold at 0100 through the control transfers
        addEntry("beq_taken", mkDec(OP_BRANCH, BR_BEQ, 0, 1, 0, 0, 7, 0, 5, 5, 3, 'h200),
                 0, 0, 4'b0100, 'h210, 1);
        addEntry("beq_not", mkDec(OP_BRANCH, BR_BEQ, 0, 0, 0, 0, 0, 0, 5, 6, 3, 'h204),
                 0, 0, 4'b0100, 'h208, 0);
        addEntry("bne_back", mkDec(OP_BRANCH, BR_BNE, 0, 0, 0, 0, 0, 0, 1, 2, 32'hfffffffe,
                 'h300), 0, 0, 4'b0100, 'h2fc, 1);
        addEntry("bltz_taken", mkDec(OP_BRANCH, BR_BLTZ, 0, 0, 0, 0, 0, 0, 32'h80000000, 0, 1,
                 'h400), 0, 0, 4'b0100, 'h408, 1);
        addEntry("bltz_not", mkDec(OP_BRANCH, BR_BLTZ, 0, 0, 0, 0, 0, 0, 1, 0, 1, 'h410),
                 0, 0, 4'b0100, 'h414, 0);
        addEntry("bgez_taken", mkDec(OP_BRANCH, BR_BGEZ, 0, 0, 0, 0, 0, 0, 0, 0, 4, 'h500),
                 0, 0, 4'b0100, 'h514, 1);
        addEntry("bgez_not", mkDec(OP_BRANCH, BR_BGEZ, 0, 0, 0, 0, 0, 0, 32'hffffffff, 0, 4,
                 'h520), 0, 0, 4'b0100, 'h524, 0);
        addEntry("jump_link", mkDec(OP_JUMP, 0, 0, 1, 0, 0, 31, 0, 0, 0, 'h400000, 'h600),
                 'h604, 1, 4'b0100, 'h400000, 1);
        addEntry("jump_plain", mkDec(OP_JUMP, 0, 0, 0, 0, 0, 0, 0, 0, 0, 'h800, 'h700),
                 'h704, 0, 4'b0100, 'h800, 1);
        for (int k = 0; k < 40; k++) begin
            d = mkDec(OP_ALU, fsel[{$random(seed)} % 4], $random(seed), 1, 0, 0,
                      ({$random(seed)} % 31) + 1, 0, $random(seed), $random(seed),
                      $random(seed), 'h1000 + 4 * k);
            addEntry("rand_alu", d, 0, 0, 0, 0, 0);
            fromModel[fromModel.size() - 1] = 1'b1;
        end
    endtask

    initial begin
        int n;
        seed     = 99;
        timeouts = 0;
        arstN    = 1'b0;
        dec      = '0;
        recValid = 1'b0;
        recModel = 1'b0;
        recName  = '0;
        recMem   = '0;
        recFlags = '0;
        recPc    = '0;
        recTaken = 1'b0;
        buildTable();

        repeat (10) @(posedge Clock);
        arstN <= 1'b1;
        n = 0;
        while (arstN !== 1'b1 && n < 5) begin
            @(posedge Clock);
            n++;
        end
        if (arstN !== 1'b1) begin
            $display("Timeout: reset was not released");
            timeouts++;
        end
        repeat (2) @(posedge Clock);      // Idle outputs checked here

        for (int i = 0; i < decs.size(); i++) begin
            @(posedge Clock);
            dec      <= decs[i];
            recValid <= 1'b1;
            recModel <= fromModel[i];
            recName  <= names[i];
            recMem   <= expMems[i];
            recFlags <= expFlags[i];
            recPc    <= expPcs[i];
            recTaken <= expTakens[i];
        end
        @(posedge Clock);
        dec      <= '0;                   // Bubble
        recValid <= 1'b0;

        // Drain the two entries still in flight
        n = 0;
        do begin
            @(posedge Clock);
            n++;
        end while (busy && n < 10);
        if (busy) begin
            $display("Timeout: pipeline did not drain");
            timeouts++;
        end

        $display("Errors: %0d mismatches, %0d timeouts, %0d checks",
                 errorCount, timeouts, checkCount);
        if (errorCount == 0 && timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* verif/exChecker.sv */
/*
 * Execute stage checker: tracks drive records through the 2-cycle pipeline,
 * derives expected ALU values for random entries and compares DUT outputs
 */
`timescale 1ns/1ps

module exChecker (
    input  logic            Clock,
    input  logic            arstN,
    input  exPkg::exDecode_s dec,
    input  exPkg::exMem_s   exMem,
    input  exPkg::exFlags_s flags,
    input  logic [31:0]     pcOut,
    input  logic            taken,
    input  logic            recValid,
    input  logic            recModel,
    input  logic [127:0]    recName,
    input  exPkg::exMem_s   recMem,
    input  exPkg::exFlags_s recFlags,
    input  logic [31:0]     recPc,
    input  logic            recTaken,
    output int              errorCount,
    output int              checkCount,
    output logic            busy
);
    import exPkg::*;

    typedef struct packed {
        logic         valid;
        logic         model;
        logic [127:0] name;
        exDecode_s    dec;
        exMem_s       mem;
        exFlags_s     flags;
        logic [31:0]  pc;
        logic         taken;
    } driveRec_s;

    driveRec_s newer;                     // Applied one edge ago
    driveRec_s older;                     // Due at the outputs now

    assign busy = newer.valid | older.valid;

    task automatic compareValue(input logic [127:0] name, input logic [63:0] field,
                                input logic [72:0] exp, input logic [72:0] act);
        checkCount++;
        if (exp !== act) begin
            errorCount++;
            $display("[FAIL] %0s %0s expected %h actual %h", name, field, exp, act);
        end
    endtask

    // Expected result and {c,z,o,n} for ADD/SUB/AND/XOR, from the ALU rules
    function automatic logic [35:0] modelAlu(input exDecode_s d);
        logic [31:0]        y;
        logic [31:0]        r;
        logic signed [63:0] wide;
        logic               c;
        logic               o;
        y    = d.aluSrc ? d.immediate : d.b;
        c    = 1'b0;
        o    = 1'b0;
        wide = 0;
        case (d.func.alu)
            ALU_ADD: begin
                r    = d.a + y;
                c    = (64'(d.a) + 64'(y)) > 64'hffffffff;
                wide = 64'($signed(d.a)) + 64'($signed(y));
                o    = (wide > 64'sd2147483647) || (wide < -64'sd2147483648);
            end
            ALU_SUB: begin
                r    = d.a - y;
                c    = (d.a >= y);        // No borrow
                wide = 64'($signed(d.a)) - 64'($signed(y));
                o    = (wide > 64'sd2147483647) || (wide < -64'sd2147483648);
            end
            ALU_AND: r = d.a & y;
            default: r = d.a ^ y;
        endcase
        return {r, c, (r == 0), o, r[31]};
    endfunction

    task automatic checkRecord(input driveRec_s rec);
        exMem_s      m;
        exFlags_s    f;
        logic [31:0] pc;
        logic        tk;
        logic [35:0] alu;
        m  = rec.mem;
        f  = rec.flags;
        pc = rec.pc;
        tk = rec.taken;
        if (rec.model) begin
            alu = modelAlu(rec.dec);
            m   = '{result: alu[35:4], rtData: rec.dec.b, rAddr: rec.dec.rAddr,
                    regWrite: rec.dec.regWrite, memRead: rec.dec.memRead,
                    memtoReg: rec.dec.memtoReg, memWrite: rec.dec.memWrite};
            f   = alu[3:0];
            pc  = rec.dec.pc + 32'd4;
            tk  = 1'b0;
        end
        compareValue(rec.name, "exMem", m, exMem);
        compareValue(rec.name, "flags", f, flags);
        compareValue(rec.name, "pcOut", pc, pcOut);
        compareValue(rec.name, "taken", tk, taken);
    endtask

    // Sampled mid-cycle, away from the driving edge
    always @(negedge Clock or negedge arstN) begin
        if (!arstN) begin
            newer <= '0;
            older <= '0;
        end else begin
            if (older.valid) begin
                checkRecord(older);
            end else begin
                // Reset state and bubbles leave controls low and result zero
                compareValue("idle", "controls", 73'd0,
                             {exMem.result, exMem.regWrite, exMem.memRead,
                              exMem.memWrite, taken});
            end
            older <= newer;
            newer <= '{valid: recValid, model: recModel, name: recName, dec: dec,
                       mem: recMem, flags: recFlags, pc: recPc, taken: recTaken};
        end
    end

    initial begin
        errorCount = 0;
        checkCount = 0;
    end

endmodule

/* hw/exStage.sv */
/*
 * Execute stage top: ID/EX latch, ALU, multiply/accumulate, branch unit,
 * result selection and EX/MEM register
 */
`timescale 1ns/1ps

module exStage (
    input  logic             Clock,
    input  logic             arstN,
    input  exPkg::exDecode_s dec,
    output exPkg::exMem_s    exMem,
    output exPkg::exFlags_s  flags,
    output logic [31:0]      pcOut,
    output logic             taken
);
    import exPkg::*;

    exOperands_s ops;
    logic [31:0] aluResult;
    exFlags_s    aluFlags;
    logic [31:0] mulResult;
    exFlags_s    mulFlags;
    logic [31:0] target;
    logic [31:0] retAddr;
    logic        brTaken;

    // ------------------------------------------------------------------
    // ID/EX register
    // ------------------------------------------------------------------

    exOperandLatch i_exOperandLatch (
        .Clock (Clock),
        .arstN (arstN),
        .dec   (dec),
        .ops   (ops)
    );

    // ------------------------------------------------------------------
    // Execution units
    // ------------------------------------------------------------------

    exAlu i_exAlu (
        .ops    (ops),
        .result (aluResult),
        .flags  (aluFlags)
    );

    exMulAcc i_exMulAcc (
        .Clock  (Clock),
        .arstN  (arstN),
        .ops    (ops),
        .result (mulResult),
        .flags  (mulFlags)
    );

    exBranch i_exBranch (
        .ops     (ops),
        .target  (target),
        .retAddr (retAddr),
        .taken   (brTaken)
    );

    // ------------------------------------------------------------------
    // Result select and EX/MEM register
    // ------------------------------------------------------------------

    exResultStage i_exResultStage (
        .Clock     (Clock),
        .arstN     (arstN),
        .ops       (ops),
        .aluResult (aluResult),
        .aluFlags  (aluFlags),
        .mulResult (mulResult),
        .mulFlags  (mulFlags),
        .target    (target),
        .retAddr   (retAddr),
        .brTaken   (brTaken),
        .exMem     (exMem),
        .flags     (flags),
        .pcOut     (pcOut),
        .taken     (taken)
    );

endmodule

/* hw/exResultStage.sv */
/*
 * Result and flag selection per op class, write gating, EX/MEM register
 */
`timescale 1ns/1ps

module exResultStage (
    input  logic               Clock,
    input  logic               arstN,
    input  exPkg::exOperands_s ops,
    input  logic [31:0]        aluResult,
    input  exPkg::exFlags_s    aluFlags,
    input  logic [31:0]        mulResult,
    input  exPkg::exFlags_s    mulFlags,
    input  logic [31:0]        target,
    input  logic [31:0]        retAddr,
    input  logic               brTaken,
    output exPkg::exMem_s      exMem,
    output exPkg::exFlags_s    flags,
    output logic [31:0]        pcOut,
    output logic               taken
);
    import exPkg::*;

    exMem_s      memNext;
    exFlags_s    flagsNext;
    logic [31:0] pcNext;
    logic        takenNext;

    always_comb begin
        memNext.result   = '0;
        memNext.rtData   = ops.b;         // Store data
        memNext.rAddr    = ops.rAddr;
        memNext.regWrite = ops.regWrite;
        memNext.memRead  = ops.memRead;
        memNext.memtoReg = ops.memtoReg;
        memNext.memWrite = ops.memWrite;
        flagsNext        = flags;         // Held unless a unit updates them
        pcNext           = retAddr;
        takenNext        = 1'b0;

        unique case (ops.opClass)
            OP_ALU: begin
                memNext.result = aluResult;
                flagsNext      = aluFlags;
            end
            OP_MULACC: begin
                memNext.result = mulResult;
                flagsNext      = mulFlags;
            end
            OP_BRANCH: begin
                memNext.regWrite = 1'b0;
                pcNext           = target;
                takenNext        = brTaken;
            end
            OP_JUMP: begin
                memNext.result = retAddr; // Link address
                pcNext         = target;
                takenNext      = brTaken;
            end
            default: memNext.regWrite = 1'b0;
        endcase
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            exMem <= '0;
            flags <= '0;
            pcOut <= '0;
            taken <= 1'b0;
        end else begin
            exMem <= memNext;
            flags <= flagsNext;
            pcOut <= pcNext;
            taken <= takenNext;
        end
    end

    // Control transfers never carry a store
    noTakenWithStore : assert property (
        @(posedge Clock) disable iff (!arstN)
        !(taken && exMem.memWrite)
    ) else $error("taken asserted together with memWrite");

endmodule

/* hw/exBranch.sv */
/*
 * Branch condition evaluation, branch and jump target, return address
 */
`timescale 1ns/1ps

module exBranch (
    input  exPkg::exOperands_s ops,
    output logic [31:0]        target,
    output logic [31:0]        retAddr,
    output logic               taken
);
    import exPkg::*;

    logic [31:0] brTarget;
    logic        cond;

    assign retAddr  = ops.pc + 32'd4;
    assign brTarget = retAddr + {ops.immediate[29:0], 2'b00}; // Word offset

    always_comb begin
        unique case (ops.func.br)
            BR_BEQ:  cond = (ops.a == ops.b);
            BR_BNE:  cond = (ops.a != ops.b);
            BR_BLTZ: cond = ops.a[31];
            BR_BGEZ: cond = !ops.a[31];
            default: cond = 1'b0;
        endcase
    end

    // Target is the next pc, so a branch not taken falls through
    always_comb begin
        unique case (ops.opClass)
            OP_BRANCH: begin
                taken  = cond;
                target = cond ? brTarget : retAddr;
            end
            OP_JUMP: begin
                taken  = 1'b1;            // Unconditional
                target = ops.immediate;   // Absolute
            end
            default: begin
                taken  = 1'b0;
                target = retAddr;
            end
        endcase
    end

endmodule

/* hw/exMulAcc.sv */
/*
 * Signed 32x32 multiplier with 64-bit multiply/accumulate register
 * and accumulator flags
 */
`timescale 1ns/1ps

module exMulAcc (
    input  logic               Clock,
    input  logic               arstN,
    input  exPkg::exOperands_s ops,
    output logic [31:0]        result,
    output exPkg::exFlags_s    flags
);
    import exPkg::*;

    logic signed [63:0] product;
    logic        [63:0] acc;
    logic        [64:0] maddSum;          // Carry in bit 64
    logic               accC;             // From last MADD
    logic               accO;
    logic               isMulAcc;

    assign isMulAcc = (ops.opClass == OP_MULACC);
    assign product  = $signed(ops.a) * $signed(ops.y); // Sign extended to 64
    assign maddSum  = {1'b0, acc} + {1'b0, product};

    // ------------------------------------------------------------------
    // Accumulator, updated at the edge after the operands are latched
    // ------------------------------------------------------------------

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            acc  <= '0;
            accC <= 1'b0;
            accO <= 1'b0;
        end else if (isMulAcc) begin
            unique case (ops.func.mul)
                MUL_MADD: begin
                    acc  <= maddSum[63:0];
                    accC <= maddSum[64];
                    accO <= (acc[63] == product[63]) && (maddSum[63] != acc[63]);
                end
                MUL_CLRACC: begin
                    acc  <= '0;
                    accC <= 1'b0;         // Cleared with the sum
                    accO <= 1'b0;
                end
                default: ;                // Others only read
            endcase
        end
    end

    // Reads see the value from before the update edge
    always_comb begin
        unique case (ops.func.mul)
            MUL_MULT: result = product[31:0];
            MUL_MFLO: result = acc[31:0];
            MUL_MFHI: result = acc[63:32];
            default:  result = '0;
        endcase
    end

    assign flags = '{
        c: accC,
        z: (acc == 64'd0),
        o: accO,
        n: acc[63]
    };

    accStableOutsideMulAcc : assert property (
        @(posedge Clock) disable iff (!arstN)
        !isMulAcc |=> $stable(acc)
    ) else $error("accumulator changed outside a MULACC op");

endmodule

/* hw/exAlu.sv */
/*
 * Combinational ALU: add/sub, logic, set-less-than and shifts with C/Z/O/N flags
 */
`timescale 1ns/1ps

module exAlu (
    input  exPkg::exOperands_s ops,
    output logic [31:0]        result,
    output exPkg::exFlags_s    flags
);
    import exPkg::*;

    logic [32:0] sum;                     // Carry in bit 32
    logic        carry;
    logic        overflow;

    always_comb begin
        sum      = '0;
        carry    = 1'b0;
        overflow = 1'b0;
        result   = '0;

        unique case (ops.func.alu)
            ALU_ADD, ALU_ADDU: begin
                sum    = {1'b0, ops.a} + {1'b0, ops.y};
                result = sum[31:0];
                carry  = sum[32];
                if (ops.func.alu == ALU_ADD) begin
                    overflow = (ops.a[31] == ops.y[31]) && (sum[31] != ops.a[31]);
                end
            end
            ALU_SUB, ALU_SUBU: begin
                // a + ~y + 1, carry out is the inverted borrow
                sum    = {1'b0, ops.a} + {1'b0, ~ops.y} + 33'd1;
                result = sum[31:0];
                carry  = sum[32];
                if (ops.func.alu == ALU_SUB) begin
                    overflow = (ops.a[31] != ops.y[31]) && (sum[31] != ops.a[31]);
                end
            end
            ALU_AND:  result = ops.a & ops.y;
            ALU_OR:   result = ops.a | ops.y;
            ALU_XOR:  result = ops.a ^ ops.y;
            ALU_NOR:  result = ~(ops.a | ops.y);
            ALU_SLT:  result = {31'd0, $signed(ops.a) < $signed(ops.y)};
            ALU_SLTU: result = {31'd0, ops.a < ops.y};
            // Shifts act on the rt operand, as in MIPS
            ALU_SLL:  result = ops.y << ops.shamt;
            ALU_SRL:  result = ops.y >> ops.shamt;
            ALU_SRA:  result = $signed(ops.y) >>> ops.shamt;
            default:  result = '0;
        endcase
    end

    assign flags = '{
        c: carry,
        z: (result == 32'd0),
        o: overflow,
        n: result[31]
    };

endmodule

/* hw/exOperandLatch.sv */
/*
 * ID/EX pipeline register with ALUSrc operand selection
 */
`timescale 1ns/1ps

module exOperandLatch (
    input  logic               Clock,
    input  logic               arstN,
    input  exPkg::exDecode_s   dec,
    output exPkg::exOperands_s ops
);
    import exPkg::*;

    exOperands_s opsNext;

    always_comb begin
        opsNext.opClass   = dec.opClass;
        opsNext.func      = dec.func;
        opsNext.regWrite  = dec.regWrite;
        opsNext.memRead   = dec.memRead;
        opsNext.memtoReg  = dec.memtoReg;
        opsNext.memWrite  = dec.memWrite;
        opsNext.rAddr     = dec.rAddr;
        opsNext.shamt     = dec.shamt;
        opsNext.a         = dec.a;
        opsNext.b         = dec.b;
        opsNext.y         = dec.aluSrc ? dec.immediate : dec.b; // Operand B mux
        opsNext.immediate = dec.immediate;
        opsNext.pc        = dec.pc;
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            ops         <= '0;
            ops.opClass <= OP_NONE;       // Comes out of reset as a bubble
        end else begin
            ops         <= opsNext;
        end
    end

    // Register zero is hardwired, decode must never request a write to it
    latchedWriteAddr : assert property (
        @(posedge Clock) disable iff (!arstN)
        ops.regWrite |-> (ops.rAddr != 5'd0)
    ) else $error("latched regWrite with rAddr zero");

endmodule

/* hw/exPkg.sv */
/*
 * Execute stage types: op class and function encodings, the function-field
 * union, decode, operand, EX/MEM and flag bundles
 */
package exPkg;

    // ------------------------------------------------------------------
    // Operation encodings
    // ------------------------------------------------------------------

    typedef enum logic [2:0] {
        OP_NONE   = 3'd0,                 // Bubble
        OP_ALU    = 3'd1,
        OP_MULACC = 3'd2,
        OP_BRANCH = 3'd3,
        OP_JUMP   = 3'd4
    } opClass_e;

    // MIPS funct codes where one exists
    typedef enum logic [5:0] {
        ALU_SLL  = 6'h00,
        ALU_SRL  = 6'h02,
        ALU_SRA  = 6'h03,
        ALU_ADD  = 6'h20,
        ALU_ADDU = 6'h21,
        ALU_SUB  = 6'h22,
        ALU_SUBU = 6'h23,
        ALU_AND  = 6'h24,
        ALU_OR   = 6'h25,
        ALU_XOR  = 6'h26,
        ALU_NOR  = 6'h27,
        ALU_SLT  = 6'h2a,
        ALU_SLTU = 6'h2b
    } aluFunc_e;

    typedef enum logic [5:0] {
        MUL_MFHI   = 6'h10,
        MUL_MFLO   = 6'h12,
        MUL_MULT   = 6'h18,               // Low product word
        MUL_MADD   = 6'h1c,               // Acc += product
        MUL_CLRACC = 6'h3f
    } mulFunc_e;

    typedef enum logic [5:0] {
        BR_BLTZ = 6'h01,
        BR_BEQ  = 6'h04,
        BR_BNE  = 6'h05,
        BR_BGEZ = 6'h11
    } brFunc_e;

    // Same 6 bits, meaning depends on opClass
    typedef union packed {
        aluFunc_e alu;
        mulFunc_e mul;
        brFunc_e  br;
    } exFunc_u;

    // ------------------------------------------------------------------
    // Bundles
    // ------------------------------------------------------------------

    typedef struct packed {
        opClass_e    opClass;
        exFunc_u     func;
        logic        aluSrc;              // 1 selects immediate
        logic        regWrite;
        logic        memRead;
        logic        memtoReg;
        logic        memWrite;
        logic [4:0]  rAddr;
        logic [4:0]  shamt;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immediate;
        logic [31:0] pc;
    } exDecode_s;

    // Registered ID/EX view, operand mux already applied
    typedef struct packed {
        opClass_e    opClass;
        exFunc_u     func;
        logic        regWrite;
        logic        memRead;
        logic        memtoReg;
        logic        memWrite;
        logic [4:0]  rAddr;
        logic [4:0]  shamt;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] y;                   // Second ALU operand
        logic [31:0] immediate;
        logic [31:0] pc;
    } exOperands_s;

    typedef struct packed {
        logic [31:0] result;
        logic [31:0] rtData;
        logic [4:0]  rAddr;
        logic        regWrite;
        logic        memRead;
        logic        memtoReg;
        logic        memWrite;
    } exMem_s;

    typedef struct packed {
        logic c;
        logic z;
        logic o;
        logic n;
    } exFlags_s;

endpackage
